// File: common/me_macros.svh
`ifndef ME_MACROS_SVH
`define ME_MACROS_SVH

// pixel and word geometry.
`define ME_PIXEL_W       8
`define ME_PIX_PER_WORD  4

// block and window sides in pixels.
`define ME_BLOCK_N       4
`define ME_WIN_N         8

// displacements per axis, WIN_N - BLOCK_N + 1.
`define ME_SEARCH_N      5

// input words per block and per window.
`define ME_CUR_WORDS     4
`define ME_WIN_WORDS     16

// 16 * 255 needs 12 bits.
`define ME_SAD_W         12
`define ME_RESULT_W      20

`endif

// File: common/me_pkg.sv
`include "me_macros.svh"

package me_pkg;

    typedef logic [`ME_PIXEL_W-1:0] pixel_t;
    typedef logic [`ME_PIXEL_W*`ME_PIX_PER_WORD-1:0] word_t;  // pixel 0 in low byte.

    // row-major, pixel (r,c) at index r*N+c.
    typedef logic [`ME_BLOCK_N*`ME_BLOCK_N*`ME_PIXEL_W-1:0] cur_block_t;
    typedef logic [`ME_WIN_N*`ME_WIN_N*`ME_PIXEL_W-1:0] window_t;

    typedef logic [`ME_SAD_W-1:0] sad_t;
    typedef logic [7:0] coord_t;  // {dy, dx}.
    typedef logic [`ME_RESULT_W-1:0] result_t;  // {sad, coord}.

    typedef enum logic {
        LOAD_CUR,
        LOAD_WIN
    } loader_state_e;

    typedef enum logic {
        SER_IDLE,
        SER_SHIFT
    } ser_state_e;

endpackage

// File: loader/block_loader.sv
`timescale 1ns/1ps
`include "me_macros.svh"

module block_loader (
    input  logic               clk,
    input  logic               rst,
    input  logic               init,
    input  me_pkg::word_t      input_raw,
    output me_pkg::cur_block_t cur_block,
    output me_pkg::window_t    window,
    output logic               search_start
);

    localparam int WORD_W    = `ME_PIXEL_W * `ME_PIX_PER_WORD;
    localparam int LAST_CUR  = `ME_CUR_WORDS - 1;
    localparam int LAST_WORD = `ME_CUR_WORDS + `ME_WIN_WORDS - 1;

    me_pkg::loader_state_e state;
    logic [4:0]            word_cnt;
    logic [1:0]            cur_idx;
    logic [3:0]            win_idx;

    assign cur_idx = word_cnt[1:0];
    assign win_idx = 4'(word_cnt - 5'(`ME_CUR_WORDS));  // window word 0..15.

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= me_pkg::LOAD_CUR;
            word_cnt     <= '0;
            search_start <= 1'b0;
        end else begin
            search_start <= 1'b0;
            if (!init) begin
                state    <= me_pkg::LOAD_CUR;  // partial block is dropped.
                word_cnt <= '0;
            end else begin
                case (state)
                    me_pkg::LOAD_CUR: begin
                        word_cnt <= word_cnt + 5'd1;
                        if (word_cnt == 5'(LAST_CUR)) begin
                            state <= me_pkg::LOAD_WIN;
                        end
                    end
                    me_pkg::LOAD_WIN: begin
                        if (word_cnt == 5'(LAST_WORD)) begin
                            state        <= me_pkg::LOAD_CUR;
                            word_cnt     <= '0;
                            search_start <= 1'b1;  // block and window complete.
                        end else begin
                            word_cnt <= word_cnt + 5'd1;
                        end
                    end
                    default: begin
                        state    <= me_pkg::LOAD_CUR;
                        word_cnt <= '0;
                    end
                endcase
            end
        end
    end

    // one word is one block row or half a window row.
    always_ff @(posedge clk) begin
        if (init) begin
            if (state == me_pkg::LOAD_CUR) begin
                cur_block[cur_idx*WORD_W +: WORD_W] <= input_raw;
            end else begin
                window[win_idx*WORD_W +: WORD_W] <= input_raw;
            end
        end
    end

    a_start_single: assert property (
        @(posedge clk) disable iff (rst) search_start |=> !search_start
    );

endmodule

// File: search/sad_pe.sv
`timescale 1ns/1ps
`include "me_macros.svh"

module sad_pe #(
    parameter int DX = 0,
    parameter int DY = 0
) (
    input  logic               clk,
    input  logic               rst,
    input  me_pkg::cur_block_t cur_block,
    input  me_pkg::window_t    window,
    input  logic               en,
    output me_pkg::sad_t       sad
);

    localparam int N = `ME_BLOCK_N;
    localparam int W = `ME_PIXEL_W;

    me_pkg::sad_t sum_abs;

    always_comb begin
        me_pkg::pixel_t cur_px;
        me_pkg::pixel_t win_px;
        me_pkg::pixel_t diff;
        sum_abs = '0;
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                cur_px = cur_block[(r*N + c)*W +: W];
                win_px = window[((r + DY)*`ME_WIN_N + c + DX)*W +: W];  // patch at (DY,DX).
                diff = (cur_px > win_px) ? cur_px - win_px : win_px - cur_px;
                sum_abs = sum_abs + me_pkg::sad_t'(diff);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sad <= '0;
        end else if (en) begin
            sad <= sum_abs;
        end
    end

endmodule

// File: search/motion_search.sv
`timescale 1ns/1ps
`include "me_macros.svh"

module motion_search (
    input  logic               clk,
    input  logic               rst,
    input  me_pkg::cur_block_t cur_block,
    input  me_pkg::window_t    window,
    input  logic               search_start,
    output me_pkg::result_t    best_result,
    output logic               best_valid
);

    localparam int S        = `ME_SEARCH_N;
    localparam int NUM_CAND = S * S;

    me_pkg::sad_t   sads [NUM_CAND];
    logic           sad_valid;
    me_pkg::sad_t   min_sad;
    me_pkg::coord_t min_coord;

    for (genvar gy = 0; gy < S; gy++) begin : g_row
        for (genvar gx = 0; gx < S; gx++) begin : g_col
            sad_pe #(
                .DX(gx),
                .DY(gy)
            ) sad_pe_1 (
                .clk(clk),
                .rst(rst),
                .cur_block(cur_block),
                .window(window),
                .en(search_start),
                .sad(sads[gy*S + gx])
            );
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sad_valid <= 1'b0;
        end else begin
            sad_valid <= search_start;  // pe outputs settle one edge later.
        end
    end

    // strict less-than, so ties keep the lowest index.
    always_comb begin
        min_sad   = sads[0];
        min_coord = '0;
        for (int i = 1; i < NUM_CAND; i++) begin
            if (sads[i] < min_sad) begin
                min_sad   = sads[i];
                min_coord = {4'(i / S), 4'(i % S)};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            best_valid <= 1'b0;
        end else begin
            best_valid <= sad_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (sad_valid) begin
            best_result <= {min_sad, min_coord};
        end
    end

    a_coord_range: assert property (
        @(posedge clk) disable iff (rst)
        best_valid |-> (best_result[7:4] < 4'(S)) && (best_result[3:0] < 4'(S))
    );

endmodule

// File: logic/result_serializer.sv
`timescale 1ns/1ps
`include "me_macros.svh"

module result_serializer (
    input  logic            clk,
    input  logic            rst,
    input  me_pkg::result_t best_result,
    input  logic            best_valid,
    output logic            serial20,
    output logic            serial_valid
);

    localparam int LAST_BIT = `ME_RESULT_W - 1;

    me_pkg::ser_state_e state;
    logic [4:0]         bit_cnt;
    me_pkg::result_t    shift_reg;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= me_pkg::SER_IDLE;
            bit_cnt   <= '0;
            shift_reg <= '0;
        end else begin
            case (state)
                me_pkg::SER_IDLE: begin
                    if (best_valid) begin
                        state     <= me_pkg::SER_SHIFT;
                        bit_cnt   <= '0;
                        shift_reg <= best_result;
                    end
                end
                me_pkg::SER_SHIFT: begin
                    if (bit_cnt == 5'(LAST_BIT) && best_valid) begin
                        bit_cnt   <= '0;  // back-to-back frame.
                        shift_reg <= best_result;
                    end else begin
                        shift_reg <= shift_reg << 1;  // zeros fill behind.
                        bit_cnt   <= bit_cnt + 5'd1;
                        if (bit_cnt == 5'(LAST_BIT)) begin
                            state <= me_pkg::SER_IDLE;
                        end
                    end
                end
                default: begin
                    state <= me_pkg::SER_IDLE;
                end
            endcase
        end
    end

    assign serial20     = shift_reg[LAST_BIT];  // msb first.
    assign serial_valid = (state == me_pkg::SER_SHIFT);

    a_no_overrun: assert property (
        @(posedge clk) disable iff (rst)
        best_valid |-> (state == me_pkg::SER_IDLE) || (bit_cnt == 5'(LAST_BIT))
    );

endmodule

// File: logic/me_top.sv
`timescale 1ns/1ps

module me_top (
    input  logic          clk,
    input  logic          rst,
    input  logic          init,
    input  me_pkg::word_t input_raw,
    output logic          serial20,
    output logic          serial_valid
);

    me_pkg::cur_block_t cur_block;
    me_pkg::window_t    window;
    logic               search_start;
    me_pkg::result_t    best_result;
    logic               best_valid;

    block_loader block_loader_1 (
        .clk(clk),
        .rst(rst),
        .init(init),
        .input_raw(input_raw),
        .cur_block(cur_block),
        .window(window),
        .search_start(search_start)
    );

    motion_search motion_search_1 (
        .clk(clk),
        .rst(rst),
        .cur_block(cur_block),
        .window(window),
        .search_start(search_start),
        .best_result(best_result),
        .best_valid(best_valid)
    );

    result_serializer result_serializer_1 (
        .clk(clk),
        .rst(rst),
        .best_result(best_result),
        .best_valid(best_valid),
        .serial20(serial20),
        .serial_valid(serial_valid)
    );

endmodule

// File: dv/me_ref_model.svh
`ifndef ME_REF_MODEL_SVH
`define ME_REF_MODEL_SVH

// sum of absolute differences of the block against the patch at (dy,dx).
function automatic int ref_sad(
    input logic [7:0] cur [`ME_BLOCK_N*`ME_BLOCK_N],
    input logic [7:0] win [`ME_WIN_N*`ME_WIN_N],
    input int         dy,
    input int         dx
);
    int sum;
    int a;
    int b;
    sum = 0;
    for (int r = 0; r < `ME_BLOCK_N; r++) begin
        for (int c = 0; c < `ME_BLOCK_N; c++) begin
            a = int'(cur[r*`ME_BLOCK_N + c]);
            b = int'(win[(r + dy)*`ME_WIN_N + c + dx]);
            sum = sum + ((a > b) ? a - b : b - a);
        end
    end
    return sum;
endfunction

// scan in index order dy*5+dx; only a strictly smaller sad replaces the best.
function automatic logic [19:0] ref_best(
    input logic [7:0] cur [`ME_BLOCK_N*`ME_BLOCK_N],
    input logic [7:0] win [`ME_WIN_N*`ME_WIN_N]
);
    int best_sad;
    int best_dy;
    int best_dx;
    int s;
    best_sad = ref_sad(cur, win, 0, 0);
    best_dy  = 0;
    best_dx  = 0;
    for (int dy = 0; dy < `ME_SEARCH_N; dy++) begin
        for (int dx = 0; dx < `ME_SEARCH_N; dx++) begin
            s = ref_sad(cur, win, dy, dx);
            if (s < best_sad) begin
                best_sad = s;
                best_dy  = dy;
                best_dx  = dx;
            end
        end
    end
    return {12'(best_sad), 4'(best_dy), 4'(best_dx)};
endfunction

`endif

// File: dv/tb_me_top.sv
`timescale 1ns/1ps
`include "me_macros.svh"

module tb_me_top;

    localparam int WORDS          = `ME_CUR_WORDS + `ME_WIN_WORDS;
    localparam int CUR_PIX        = `ME_BLOCK_N * `ME_BLOCK_N;
    localparam int WIN_PIX        = `ME_WIN_N * `ME_WIN_N;
    localparam int TIMEOUT_CYCLES = 400;  // six blocks of about 44 cycles, plus margin.

    logic          clk = 1'b0;
    logic          rst;
    logic          init;
    me_pkg::word_t input_raw;
    logic          serial20;
    logic          serial_valid;

    logic [7:0]    cur_px [CUR_PIX];
    logic [7:0]    win_px [WIN_PIX];
    logic [19:0]   exp_q [$];
    logic [19:0]   exp_now = '0;
    logic          last_word;
    logic [3:0]    e0_dly = '0;
    int            blocks_loaded = 0;
    int            cycle_cnt = 0;
    int            value_errs = 0;
    int            proto_errs = 0;

    logic          sv_prev = 1'b0;
    logic [5:0]    frame_len = '0;
    logic [19:0]   frame_bits = '0;
    logic          frame_ready = 1'b0;
    logic          orphan_frame = 1'b0;

`include "me_ref_model.svh"

    me_top i_dut (
        .clk(clk),
        .rst(rst),
        .init(init),
        .input_raw(input_raw),
        .serial20(serial20),
        .serial_valid(serial_valid)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (rst) begin
            e0_dly <= '0;
        end else begin
            e0_dly <= {e0_dly[2:0], init && last_word};  // this edge takes word 20.
            if (init && last_word) begin
                blocks_loaded <= blocks_loaded + 1;
            end
        end
    end

    // serial capture, mid-cycle.
    always @(negedge clk) begin
        sv_prev      <= serial_valid;
        frame_ready  <= 1'b0;
        orphan_frame <= 1'b0;
        if (serial_valid) begin
            frame_bits <= {frame_bits[18:0], serial20};  // msb arrives first.
            frame_len  <= sv_prev ? frame_len + 6'd1 : 6'd1;
            if (sv_prev && frame_len == 6'd19) begin
                if (exp_q.size() == 0) begin
                    orphan_frame <= 1'b1;
                end else begin
                    exp_now     <= exp_q.pop_front();
                    frame_ready <= 1'b1;
                end
            end
        end
    end

    a_quiet_before_load: assert property (
        @(posedge clk) disable iff (rst)
        (blocks_loaded == 0) |-> !serial_valid && !serial20
    ) else begin
        value_errs = value_errs + 1;
        $display("** Error @%0t: serial output active before any block was loaded", $time);
    end

    a_sad_value: assert property (
        @(posedge clk) disable iff (rst) frame_ready |-> frame_bits[19:8] == exp_now[19:8]
    ) else begin
        value_errs = value_errs + 1;
        $display("** Error @%0t: SAD %0d, expected %0d", $time,
                 frame_bits[19:8], exp_now[19:8]);
    end

    a_coord_value: assert property (
        @(posedge clk) disable iff (rst) frame_ready |-> frame_bits[7:0] == exp_now[7:0]
    ) else begin
        value_errs = value_errs + 1;
        $display("** Error @%0t: coordinate dy=%0d dx=%0d, expected dy=%0d dx=%0d", $time,
                 frame_bits[7:4], frame_bits[3:0], exp_now[7:4], exp_now[3:0]);
    end

    a_no_orphan: assert property (
        @(posedge clk) disable iff (rst) !orphan_frame
    ) else begin
        proto_errs = proto_errs + 1;
        $display("A result frame arrived at %0t with no block waiting for it.", $time);
    end

    a_start_latency: assert property (
        @(posedge clk) disable iff (rst) $rose(serial_valid) |-> e0_dly[3]
    ) else begin
        proto_errs = proto_errs + 1;
        $display("serial_valid rose at %0t, not three edges after word 20.", $time);
    end

    a_start_missing: assert property (
        @(posedge clk) disable iff (rst) e0_dly[3] |-> serial_valid
    ) else begin
        proto_errs = proto_errs + 1;
        $display("serial_valid was still low at %0t, three edges after word 20.", $time);
    end

    a_frame_max: assert property (
        @(posedge clk) disable iff (rst) serial_valid |-> frame_len <= 6'd20
    ) else begin
        proto_errs = proto_errs + 1;
        $display("serial_valid stayed high longer than 20 cycles at %0t.", $time);
    end

    a_frame_len: assert property (
        @(posedge clk) disable iff (rst) $fell(serial_valid) |-> frame_len == 6'd20
    ) else begin
        proto_errs = proto_errs + 1;
        $display("A frame ended at %0t after %0d cycles instead of 20.", $time, frame_len);
    end

    // window words: row r at 4+2r and 5+2r, so pixel base is (w-4)*4.
    function automatic me_pkg::word_t input_word(input int w);
        int b;
        if (w < `ME_CUR_WORDS) begin
            b = w * 4;
            return {cur_px[b+3], cur_px[b+2], cur_px[b+1], cur_px[b]};
        end
        b = (w - `ME_CUR_WORDS) * 4;
        return {win_px[b+3], win_px[b+2], win_px[b+1], win_px[b]};
    endfunction

    task automatic fill_random;
        for (int i = 0; i < CUR_PIX; i++) begin
            cur_px[i] = 8'($urandom);
        end
        for (int i = 0; i < WIN_PIX; i++) begin
            win_px[i] = 8'($urandom);
        end
    endtask

    task automatic plant_copy(input int dy, input int dx);
        for (int r = 0; r < `ME_BLOCK_N; r++) begin
            for (int c = 0; c < `ME_BLOCK_N; c++) begin
                win_px[(r + dy)*`ME_WIN_N + c + dx] = cur_px[r*`ME_BLOCK_N + c];
            end
        end
    endtask

    task automatic fill_uniform(input int a, input int b);
        for (int i = 0; i < CUR_PIX; i++) begin
            cur_px[i] = 8'(a);
        end
        for (int i = 0; i < WIN_PIX; i++) begin
            win_px[i] = 8'(b);
        end
    endtask

    // 20 words, then init low for one cycle.
    task automatic load_block;
        for (int w = 0; w < WORDS; w++) begin
            @(negedge clk);
            init      = 1'b1;
            input_raw = input_word(w);
            last_word = (w == WORDS - 1);
        end
        @(negedge clk);
        init      = 1'b0;
        last_word = 1'b0;
        input_raw = '0;
    endtask

    task automatic wait_results;
        while (exp_q.size() != 0 || serial_valid) begin
            @(negedge clk);
        end
    endtask

    initial begin
        int dy;
        int dx;
        int a;
        int b;
        void'($urandom(90));
        rst       = 1'b1;
        init      = 1'b0;
        input_raw = '0;
        last_word = 1'b0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        repeat (4) @(negedge clk);  // outputs must stay quiet here.

        fill_random();
        exp_q.push_back(ref_best(cur_px, win_px));
        load_block();
        wait_results();

        fill_random();
        dy = int'($urandom % 5);
        dx = int'($urandom % 5);
        plant_copy(dy, dx);
        exp_q.push_back({12'd0, 4'(dy), 4'(dx)});
        load_block();
        wait_results();

        a = int'($urandom % 256);
        b = (a + 1 + int'($urandom % 255)) % 256;
        fill_uniform(a, b);
        exp_q.push_back({12'(16 * ((a > b) ? a - b : b - a)), 8'h00});  // all tie at (0,0).
        load_block();
        wait_results();

        for (int k = 0; k < 3; k++) begin
            fill_random();
            exp_q.push_back(ref_best(cur_px, win_px));
            load_block();
        end
        wait_results();

        repeat (3) @(negedge clk);
        $display("Errors: %0d value, %0d protocol", value_errs, proto_errs);
        if (value_errs + proto_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        wait (cycle_cnt == TIMEOUT_CYCLES);
        $display("Timeout: the run did not finish within %0d cycles.", TIMEOUT_CYCLES);
        $display("Errors: %0d value, %0d protocol", value_errs, proto_errs);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: me_top.f
+incdir+common
+incdir+dv
common/me_pkg.sv
loader/block_loader.sv
search/sad_pe.sv
search/motion_search.sv
logic/result_serializer.sv
logic/me_top.sv
dv/tb_me_top.sv

// File: run.sh
#!/bin/sh
# Builds the motion estimator testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_me_top -f me_top.f -o tb_me_top

./obj_dir/tb_me_top > sim.log 2>&1 || {
    cat sim.log
    echo "simulation exited with an error status"
    exit 1
}
cat sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
    exit 1
fi
